// File: hw/mole_pkg.sv
package mole_pkg;

	// Keypad geometry and key or target codes.
	localparam int KEY_LINES = 4;
	typedef logic [3:0] key_code_t;

	// Dot matrix geometry. A target lights a square block of this edge.
	localparam int MATRIX_SIZE = 8;
	localparam int BLOCK_SIZE = 2;

	// Seven-segment patterns are active low with segment g in bit 6.
	typedef logic [6:0] seg_t;

	localparam seg_t SEG_DIGITS [0:9] = '{
		7'b1000000,
		7'b1111001,
		7'b0100100,
		7'b0110000,
		7'b0011001,
		7'b0010010,
		7'b0000010,
		7'b1111000,
		7'b0000000,
		7'b0010000
	};

	localparam int SCORE_W = 7;
	typedef logic [SCORE_W-1:0] score_t;
	localparam score_t SCORE_MAX = 7'd99;

	localparam int TIME_W = 5;
	typedef logic [TIME_W-1:0] time_t;

	localparam key_code_t START_TARGET = 4'd0;

	// An all-zero LFSR would lock up, so the seed must be nonzero.
	localparam logic [7:0] LFSR_SEED = 8'hA5;

endpackage

// File: hw/tick_gen.sv
`timescale 1ns/1ns

module tick_gen #(
	parameter int DIVIDE = 4
) (
	input  logic clk,
	input  logic rst,
	output logic tick
);

	localparam int CNT_W = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;

	logic [CNT_W-1:0] count;

	// The tick is registered, so it follows the wrap of the counter by one clock.
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			count <= '0;
			tick <= 1'b0;
		end
		else
		begin
			if (count == CNT_W'(DIVIDE - 1))
				count <= '0;
			else
				count <= count + 1'b1;
			tick <= (count == CNT_W'(DIVIDE - 1));
		end
	end

endmodule

// File: hw/key_scanner.sv
`timescale 1ns/1ns

module key_scanner
	import mole_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 scan_tick,
	input  logic [KEY_LINES-1:0] keycol,
	output logic [KEY_LINES-1:0] keyrow,
	output logic                 key_valid,
	output key_code_t            key_code
);

	localparam int IDX_W = $clog2(KEY_LINES);

	logic [IDX_W-1:0] row_idx;
	logic [IDX_W:0]   low_count;
	logic [IDX_W-1:0] low_col;

	// Only the row under test is pulled low.
	assign keyrow = ~(KEY_LINES'(1) << row_idx);

	// Count the low columns and remember which one it was.
	always_comb
	begin
		low_count = '0;
		low_col = '0;
		for (int c = 0; c < KEY_LINES; c++)
		begin
			if (!keycol[c])
			begin
				low_count = low_count + 1'b1;
				low_col = IDX_W'(c);
			end
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			row_idx <= '0;
			key_valid <= 1'b0;
		end
		else
		begin
			key_valid <= scan_tick && (low_count == 1);
			if (scan_tick)
				row_idx <= row_idx + 1'b1;
		end
	end

	// Two keys in one row at once are ambiguous and get no pulse.
	always_ff @(posedge clk)
	begin
		if (scan_tick)
			key_code <= {row_idx, low_col};
	end

endmodule

// File: hw/game_control.sv
`timescale 1ns/1ns

module game_control
	import mole_pkg::*;
#(
	parameter int GAME_SECONDS = 30
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      second_tick,
	input  logic      key_valid,
	input  key_code_t key_code,
	output key_code_t target,
	output logic      running,
	output time_t     time_left,
	output score_t    score
);

	logic [7:0] lfsr;
	logic       hit;
	key_code_t  next_target;

	// The taps follow the maximal length polynomial x^8 + x^6 + x^5 + x^4 + 1.
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			lfsr <= LFSR_SEED;
		else
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
	end

	assign running = (time_left != '0);

	assign hit = key_valid && running && (key_code == target);

	// The mole must visibly move, so a repeat is bumped to the next code.
	always_comb
	begin
		if (lfsr[3:0] == target)
			next_target = target + 1'b1;
		else
			next_target = lfsr[3:0];
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			target <= START_TARGET;
			score <= '0;
		end
		else if (hit)
		begin
			target <= next_target;
			if (score != SCORE_MAX)
				score <= score + 1'b1;
		end
	end

	// The countdown stops at zero, which also ends the game.
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			time_left <= TIME_W'(GAME_SECONDS);
		else if (second_tick && running)
			time_left <= time_left - 1'b1;
	end

endmodule

// File: hw/matrix_scanner.sv
`timescale 1ns/1ns

module matrix_scanner
	import mole_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   frame_tick,
	input  key_code_t              target,
	input  logic                   running,
	output logic [MATRIX_SIZE-1:0] dot_row,
	output logic [MATRIX_SIZE-1:0] dot_col
);

	localparam int ROW_W = $clog2(MATRIX_SIZE);

	logic [ROW_W-1:0]       row_cnt;
	logic                   in_block;
	logic [MATRIX_SIZE-1:0] block_cols;

	// Target rows come from the upper code bits, columns from the lower ones.
	assign in_block = (int'(row_cnt) / BLOCK_SIZE) == int'(target[3:2]);
	assign block_cols = {{(MATRIX_SIZE - BLOCK_SIZE){1'b0}}, {BLOCK_SIZE{1'b1}}}
		<< (int'(target[1:0]) * BLOCK_SIZE);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			row_cnt <= '0;
			dot_row <= '1;
			dot_col <= '0;
		end
		else if (frame_tick)
		begin
			if (running)
			begin
				row_cnt <= row_cnt + 1'b1;
				dot_row <= ~(MATRIX_SIZE'(1) << row_cnt);
				dot_col <= in_block ? block_cols : '0;
			end
			else
			begin
				dot_row <= '1;
				dot_col <= '0;
			end
		end
	end

endmodule

// File: hw/two_digit_display.sv
`timescale 1ns/1ns

module two_digit_display
	import mole_pkg::*;
#(
	parameter type value_t = logic [6:0]
) (
	input  value_t value,
	output seg_t   tens,
	output seg_t   ones
);

	int v;
	int tens_digit;
	int ones_digit;

	// Values of 100 or more wrap in the tens digit rather than index out of range.
	always_comb
	begin
		v = int'(value);
		tens_digit = (v / 10) % 10;
		ones_digit = v % 10;
		tens = SEG_DIGITS[tens_digit];
		ones = SEG_DIGITS[ones_digit];
	end

endmodule

// File: hw/whack_top.sv
`timescale 1ns/1ns

module whack_top
	import mole_pkg::*;
#(
	parameter int SCAN_DIV = 50000,
	parameter int FRAME_DIV = 5000,
	parameter int SECOND_DIV = 50000000,
	parameter int GAME_SECONDS = 30
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [KEY_LINES-1:0]   keycol,
	output logic [KEY_LINES-1:0]   keyrow,
	output logic [MATRIX_SIZE-1:0] dot_row,
	output logic [MATRIX_SIZE-1:0] dot_col,
	output seg_t                   t_out1,
	output seg_t                   t_out0,
	output seg_t                   dp1,
	output seg_t                   dp2
);

	logic      scan_tick;
	logic      frame_tick;
	logic      second_tick;
	logic      key_valid;
	key_code_t key_code;
	key_code_t target;
	logic      running;
	time_t     time_left;
	score_t    score;

	tick_gen #(.DIVIDE(SCAN_DIV)) u_scan_tick (
		.clk  (clk),
		.rst  (rst),
		.tick (scan_tick)
	);

	tick_gen #(.DIVIDE(FRAME_DIV)) u_frame_tick (
		.clk  (clk),
		.rst  (rst),
		.tick (frame_tick)
	);

	tick_gen #(.DIVIDE(SECOND_DIV)) u_second_tick (
		.clk  (clk),
		.rst  (rst),
		.tick (second_tick)
	);

	key_scanner u_keys (
		.clk       (clk),
		.rst       (rst),
		.scan_tick (scan_tick),
		.keycol    (keycol),
		.keyrow    (keyrow),
		.key_valid (key_valid),
		.key_code  (key_code)
	);

	game_control #(.GAME_SECONDS(GAME_SECONDS)) u_game (
		.clk         (clk),
		.rst         (rst),
		.second_tick (second_tick),
		.key_valid   (key_valid),
		.key_code    (key_code),
		.target      (target),
		.running     (running),
		.time_left   (time_left),
		.score       (score)
	);

	matrix_scanner u_matrix (
		.clk        (clk),
		.rst        (rst),
		.frame_tick (frame_tick),
		.target     (target),
		.running    (running),
		.dot_row    (dot_row),
		.dot_col    (dot_col)
	);

	// Time on one digit pair, score on the other.
	two_digit_display #(.value_t(time_t)) u_time_disp (
		.value (time_left),
		.tens  (t_out1),
		.ones  (t_out0)
	);

	two_digit_display #(.value_t(score_t)) u_score_disp (
		.value (score),
		.tens  (dp1),
		.ones  (dp2)
	);

endmodule

// File: tests/whack_asserts.sv
`timescale 1ns/1ns

module whack_asserts
	import mole_pkg::*;
(
	input logic                   clk,
	input logic                   rst,
	input logic [KEY_LINES-1:0]   keyrow,
	input logic [MATRIX_SIZE-1:0] dot_row,
	input logic [MATRIX_SIZE-1:0] dot_col,
	input logic                   frame_tick,
	input logic                   running,
	input time_t                  time_left,
	input score_t                 score
);

	keyrow_one_cold: assert property (@(posedge clk) disable iff (!rst) $onehot(~keyrow))
		else $error("keyrow is not one-cold");

	dot_row_shape: assert property (@(posedge clk) disable iff (!rst)
		$onehot(~dot_row) || dot_row == '1)
		else $error("dot_row is neither one-cold nor all ones");

	score_never_falls: assert property (@(posedge clk) disable iff (!rst)
		score >= $past(score))
		else $error("score decreased");

	time_never_rises: assert property (@(posedge clk) disable iff (!rst)
		time_left <= $past(time_left))
		else $error("time_left increased");

	// Once the game is over and a frame tick has blanked the matrix, it stays dark.
	dark_after_end: assert property (@(posedge clk) disable iff (!rst)
		(!running && (frame_tick || dot_row == '1)) |=> (dot_row == '1 && dot_col == '0))
		else $error("matrix lit after the game ended");

endmodule

bind whack_top whack_asserts u_asserts (
	.clk        (clk),
	.rst        (rst),
	.keyrow     (keyrow),
	.dot_row    (dot_row),
	.dot_col    (dot_col),
	.frame_tick (frame_tick),
	.running    (running),
	.time_left  (time_left),
	.score      (score)
);

// File: tests/whack_tb.sv
`timescale 1ns/1ns

module whack_tb
	import mole_pkg::*;
();

	localparam int SCAN_DIV = 4;
	localparam int FRAME_DIV = 2;
	localparam int SECOND_DIV = 400;
	localparam int GAME_SECONDS = 5;
	localparam int PERIOD = 40;
	localparam int HOLD_CYCLES = 4 * KEY_LINES * SCAN_DIV;
	localparam int WATCHDOG_NS = (GAME_SECONDS + 2) * SECOND_DIV * PERIOD;
	localparam int COUNTDOWN_NS = (GAME_SECONDS + 1) * SECOND_DIV * PERIOD;

	logic                   clk;
	logic                   rst;
	logic [KEY_LINES-1:0]   keycol;
	logic [KEY_LINES-1:0]   keyrow;
	logic [MATRIX_SIZE-1:0] dot_row;
	logic [MATRIX_SIZE-1:0] dot_col;
	seg_t                   t_out1;
	seg_t                   t_out0;
	seg_t                   dp1;
	seg_t                   dp2;
	logic                   press_on;
	logic [1:0]             press_row;
	logic [1:0]             press_col;
	integer                 seed;
	int                     last_target;
	time                    game_start;

	// The pressed key shorts its column to the row while that row is driven low.
	assign keycol = (press_on && !keyrow[press_row]) ? ~(4'b0001 << press_col) : 4'b1111;

	whack_top #(
		.SCAN_DIV     (SCAN_DIV),
		.FRAME_DIV    (FRAME_DIV),
		.SECOND_DIV   (SECOND_DIV),
		.GAME_SECONDS (GAME_SECONDS)
	) UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic fail_value(string name, int expected, int actual);
		$display("ERR at %0t ns: %s expected %0d, actual %0d", $time, name, expected, actual);
		abort_run();
	endtask

	task automatic fail_text(string what);
		$display("ERR at %0t ns: %s", $time, what);
		abort_run();
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		fail_text("watchdog expired before the tests finished");
	end

	function automatic int seg_value(seg_t tens, seg_t ones);
		int t;
		int o;
		t = -1;
		o = -1;
		for (int d = 0; d < 10; d++)
		begin
			if (tens == SEG_DIGITS[d])
				t = d;
			if (ones == SEG_DIGITS[d])
				o = d;
		end
		return (t < 0 || o < 0) ? -1 : 10 * t + o;
	endfunction

	task automatic press_key(int code);
		press_row = 2'(code / KEY_LINES);
		press_col = 2'(code % KEY_LINES);
		press_on = 1'b1;
	endtask

	task automatic read_target(output int code);
		logic [MATRIX_SIZE-1:0] cols [MATRIX_SIZE];
		bit                     seen [MATRIX_SIZE];
		logic [MATRIX_SIZE-1:0] expected;
		int                     lit_row;
		int                     lit_col;
		lit_row = -1;
		lit_col = -1;
		foreach (seen[r])
		begin
			seen[r] = 1'b0;
			cols[r] = '0;
		end
		// Two frames, so rows from before a target change get overwritten.
		repeat (2 * MATRIX_SIZE * FRAME_DIV)
		begin
			@(negedge clk);
			for (int r = 0; r < MATRIX_SIZE; r++)
			begin
				if (dot_row == ~(8'b1 << r))
				begin
					seen[r] = 1'b1;
					cols[r] = dot_col;
				end
			end
		end
		for (int r = MATRIX_SIZE - 1; r >= 0; r--)
		begin
			assert (seen[r]) else fail_text($sformatf("matrix row %0d was never scanned", r));
			if (cols[r] != '0)
				lit_row = r;
		end
		assert (lit_row >= 0) else fail_text("no target block is lit on the matrix");
		for (int c = MATRIX_SIZE - 1; c >= 0; c--)
		begin
			if (cols[lit_row][c])
				lit_col = c;
		end
		code = (lit_row / BLOCK_SIZE) * KEY_LINES + lit_col / BLOCK_SIZE;
		for (int r = 0; r < MATRIX_SIZE; r++)
		begin
			expected = '0;
			if (r / BLOCK_SIZE == code / KEY_LINES)
				expected = 8'b11 << (BLOCK_SIZE * (code % KEY_LINES));
			assert (cols[r] == expected)
				else fail_value($sformatf("dot_col in row %0d", r), expected, cols[r]);
		end
	endtask

	task automatic check_reset_state();
		int code;
		assert (keyrow == 4'b1110) else fail_value("keyrow", 4'b1110, keyrow);
		assert (seg_value(t_out1, t_out0) == GAME_SECONDS)
			else fail_value("time digits", GAME_SECONDS, seg_value(t_out1, t_out0));
		assert (seg_value(dp1, dp2) == 0) else fail_value("score digits", 0, seg_value(dp1, dp2));
		read_target(code);
		assert (code == START_TARGET) else fail_value("target", START_TARGET, code);
	endtask

	task automatic check_scan();
		logic [KEY_LINES-1:0] order [KEY_LINES];
		logic [KEY_LINES-1:0] prev;
		int                   idx;
		order = '{4'b1110, 4'b1101, 4'b1011, 4'b0111};
		idx = -1;
		for (int i = 0; i < KEY_LINES; i++)
		begin
			if (keyrow == order[i])
				idx = i;
		end
		assert (idx >= 0) else fail_value("keyrow", order[0], keyrow);
		repeat (KEY_LINES + 1)
		begin
			prev = keyrow;
			while (keyrow == prev)
				@(negedge clk);
			idx = (idx + 1) % KEY_LINES;
			assert (keyrow == order[idx]) else fail_value("keyrow", order[idx], keyrow);
		end
	endtask

	task automatic hit_target(output int new_target);
		int old_target;
		int old_score;
		int waited;
		read_target(old_target);
		old_score = seg_value(dp1, dp2);
		press_key(old_target);
		waited = 0;
		while (seg_value(dp1, dp2) == old_score && waited < HOLD_CYCLES)
		begin
			@(negedge clk);
			waited++;
		end
		press_on = 1'b0;
		assert (seg_value(dp1, dp2) == old_score + 1)
			else fail_value("score digits", old_score + 1, seg_value(dp1, dp2));
		read_target(new_target);
		assert (new_target != old_target) else fail_text("target did not move after a hit");
	endtask

	task automatic miss_key(output int target);
		int old_score;
		int key;
		int now_target;
		read_target(target);
		old_score = seg_value(dp1, dp2);
		key = target;
		while (key == target)
			key = $unsigned($random(seed)) % 16;
		press_key(key);
		repeat (HOLD_CYCLES) @(negedge clk);
		press_on = 1'b0;
		assert (seg_value(dp1, dp2) == old_score)
			else fail_value("score digits", old_score, seg_value(dp1, dp2));
		read_target(now_target);
		assert (now_target == target) else fail_value("target", target, now_target);
	endtask

	task automatic countdown_and_end(int former_target);
		int prev;
		int now;
		int old_score;
		prev = seg_value(t_out1, t_out0);
		while (prev != 0)
		begin
			@(negedge clk);
			now = seg_value(t_out1, t_out0);
			assert (now >= 0 && now <= prev) else fail_value("time digits", prev, now);
			assert ($time - game_start <= COUNTDOWN_NS)
				else fail_text("time digits did not reach 00 in time");
			prev = now;
		end
		// A frame tick falls within FRAME_DIV clocks and blanks the matrix.
		repeat (FRAME_DIV) @(negedge clk);
		old_score = seg_value(dp1, dp2);
		press_key(former_target);
		repeat (HOLD_CYCLES)
		begin
			assert (dot_row == 8'hFF) else fail_value("dot_row", 8'hFF, dot_row);
			assert (dot_col == 8'h00) else fail_value("dot_col", 8'h00, dot_col);
			@(negedge clk);
		end
		press_on = 1'b0;
		assert (seg_value(dp1, dp2) == old_score)
			else fail_value("score digits", old_score, seg_value(dp1, dp2));
	endtask

	initial
	begin
		seed = 2;
		rst = 1'b0;
		press_on = 1'b0;
		press_row = 2'd0;
		press_col = 2'd0;
		game_start = 0;
		repeat (4) @(negedge clk);
		rst = 1'b1;
		game_start = $time;
		check_reset_state();
		check_scan();
		repeat (3) hit_target(last_target);
		miss_key(last_target);
		countdown_and_end(last_target);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: project.f
hw/mole_pkg.sv
hw/tick_gen.sv
hw/key_scanner.sv
hw/game_control.sv
hw/matrix_scanner.sv
hw/two_digit_display.sv
hw/whack_top.sv
tests/whack_asserts.sv
tests/whack_tb.sv
